// ==== Makefile ====
# Verilator simulation of mem_req_router
VERILATOR ?= verilator
TOP       ?= tb_mem_req_router
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove build output and the log"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "TEST RESULT: PASS" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== mem_req_router.sv ====
`timescale 1ns/1ps

module mem_req_router #(
    parameter int ORDER_DEPTH = router_pkg::DEFAULT_ORDER_DEPTH
) (
    input  logic               aclk,
    input  logic               aresetn,

    // Instruction CPU side
    input  logic               inst_req,
    input  router_pkg::route_t inst_cached,
    input  router_pkg::addr_t  inst_addr,
    output router_pkg::word_t  inst_rdata,
    output logic               inst_addr_ok,
    output logic               inst_data_ok,

    // Data CPU side
    input  logic               data_req,
    input  router_pkg::route_t data_cached,
    input  logic               data_wr,
    input  router_pkg::size_t  data_size,
    input  router_pkg::addr_t  data_addr,
    input  router_pkg::word_t  data_wdata,
    input  router_pkg::strb_t  data_wstrb,
    output router_pkg::word_t  data_rdata,
    output logic               data_addr_ok,
    output logic               data_data_ok,

    // Instruction cached path
    output logic               ic_req,
    output router_pkg::addr_t  ic_addr,
    input  router_pkg::word_t  ic_rdata,
    input  logic               ic_addr_ok,
    input  logic               ic_data_ok,

    // Instruction uncached path
    output logic               iu_req,
    output router_pkg::addr_t  iu_addr,
    input  router_pkg::word_t  iu_rdata,
    input  logic               iu_addr_ok,
    input  logic               iu_data_ok,

    // Data cached path
    output logic               dc_req,
    output logic               dc_wr,
    output router_pkg::size_t  dc_size,
    output router_pkg::addr_t  dc_addr,
    output router_pkg::word_t  dc_wdata,
    output router_pkg::strb_t  dc_wstrb,
    input  router_pkg::word_t  dc_rdata,
    input  logic               dc_addr_ok,
    input  logic               dc_data_ok,

    // Data uncached path
    output logic               du_req,
    output logic               du_wr,
    output router_pkg::size_t  du_size,
    output router_pkg::addr_t  du_addr,
    output router_pkg::word_t  du_wdata,
    output router_pkg::strb_t  du_wstrb,
    input  router_pkg::word_t  du_rdata,
    input  logic               du_addr_ok,
    input  logic               du_data_ok
);

    //////////////////////////////////////////////////
    // Instruction channel
    //////////////////////////////////////////////////

    req_route_channel #(
        .ORDER_DEPTH (ORDER_DEPTH)
    ) u_inst_channel (
        .aclk      (aclk),
        .aresetn   (aresetn),
        .req       (inst_req),
        .cached    (inst_cached),
        .addr      (inst_addr),
        .rdata     (inst_rdata),
        .addr_ok   (inst_addr_ok),
        .data_ok   (inst_data_ok),
        .c_req     (ic_req),
        .c_addr    (ic_addr),
        .c_rdata   (ic_rdata),
        .c_addr_ok (ic_addr_ok),
        .c_data_ok (ic_data_ok),
        .u_req     (iu_req),
        .u_addr    (iu_addr),
        .u_rdata   (iu_rdata),
        .u_addr_ok (iu_addr_ok),
        .u_data_ok (iu_data_ok)
    );

    //////////////////////////////////////////////////
    // Data channel
    //////////////////////////////////////////////////

    req_route_channel #(
        .ORDER_DEPTH (ORDER_DEPTH)
    ) u_data_channel (
        .aclk      (aclk),
        .aresetn   (aresetn),
        .req       (data_req),
        .cached    (data_cached),
        .addr      (data_addr),
        .rdata     (data_rdata),
        .addr_ok   (data_addr_ok),
        .data_ok   (data_data_ok),
        .c_req     (dc_req),
        .c_addr    (dc_addr),
        .c_rdata   (dc_rdata),
        .c_addr_ok (dc_addr_ok),
        .c_data_ok (dc_data_ok),
        .u_req     (du_req),
        .u_addr    (du_addr),
        .u_rdata   (du_rdata),
        .u_addr_ok (du_addr_ok),
        .u_data_ok (du_data_ok)
    );

    // Write fields go to both paths, req picks the one that acts
    assign dc_wr    = data_wr;
    assign dc_size  = data_size;
    assign dc_wdata = data_wdata;
    assign dc_wstrb = data_wstrb;

    assign du_wr    = data_wr;
    assign du_size  = data_size;
    assign du_wdata = data_wdata;
    assign du_wstrb = data_wstrb;

endmodule

// ==== req_route_channel.sv ====
`timescale 1ns/1ps

module req_route_channel #(
    parameter int ORDER_DEPTH = router_pkg::DEFAULT_ORDER_DEPTH
) (
    input  logic               aclk,
    input  logic               aresetn,

    // CPU side
    input  logic               req,
    input  router_pkg::route_t cached,
    input  router_pkg::addr_t  addr,
    output router_pkg::word_t  rdata,
    output logic               addr_ok,
    output logic               data_ok,

    // Cached path
    output logic               c_req,
    output router_pkg::addr_t  c_addr,
    input  router_pkg::word_t  c_rdata,
    input  logic               c_addr_ok,
    input  logic               c_data_ok,

    // Uncached path
    output logic               u_req,
    output router_pkg::addr_t  u_addr,
    input  router_pkg::word_t  u_rdata,
    input  logic               u_addr_ok,
    input  logic               u_data_ok
);

    localparam int ADDR_W = $bits(router_pkg::addr_t);
    localparam int CLR_W  = router_pkg::MMU_CLEAR_BITS;

    logic issue_ok;
    logic path_addr_ok;

    route_fifo_if #(.DEPTH(ORDER_DEPTH)) order_if ();

    route_order_fifo #(
        .DEPTH (ORDER_DEPTH)
    ) u_order_fifo (
        .aclk    (aclk),
        .aresetn (aresetn),
        .fifo    (order_if.store)
    );

    //////////////////////////////////////////////////
    // Issue gating
    //////////////////////////////////////////////////

    // Only one path may have requests in flight at a time
    assign issue_ok = ~order_if.full &
                      (order_if.empty | (order_if.head_tag == cached));

    assign c_req = req & cached & issue_ok;
    assign u_req = req & ~cached & issue_ok;

    assign path_addr_ok = cached ? c_addr_ok : u_addr_ok;
    assign addr_ok      = path_addr_ok & issue_ok;

    // Simple MMU on the cached path only
    assign c_addr = {{CLR_W{1'b0}}, addr[ADDR_W-CLR_W-1:0]};
    assign u_addr = addr;

    //////////////////////////////////////////////////
    // Order tracking and response
    //////////////////////////////////////////////////

    assign order_if.push     = req & addr_ok;
    assign order_if.push_tag = cached;

    assign data_ok      = c_data_ok | u_data_ok;
    assign order_if.pop = data_ok;

    // Head tag names the path of the oldest request
    assign rdata = order_if.head_tag ? c_rdata : u_rdata;

    // Both paths never hold requests together, so responses cannot collide
    a_one_data_ok: assert property (
        @(posedge aclk) disable iff (!aresetn) !(c_data_ok && u_data_ok)
    ) else $error("req_route_channel: data_ok from both paths");

    a_data_ok_tracked: assert property (
        @(posedge aclk) disable iff (!aresetn) data_ok |-> !order_if.empty
    ) else $error("req_route_channel: data_ok with nothing outstanding");

endmodule

// ==== route_fifo_if.sv ====
`timescale 1ns/1ps

interface route_fifo_if #(
    parameter int DEPTH = router_pkg::DEFAULT_ORDER_DEPTH
);

    // Steering side
    logic               push;
    router_pkg::route_t push_tag;
    logic               pop;

    // Tag store side
    router_pkg::route_t           head_tag;
    logic                         empty;
    logic                         full;
    logic [$clog2(DEPTH+1)-1:0]   count;

    modport steer (
        output push,
        output push_tag,
        output pop,
        input  head_tag,
        input  empty,
        input  full,
        input  count
    );

    modport store (
        input  push,
        input  push_tag,
        input  pop,
        output head_tag,
        output empty,
        output full,
        output count
    );

endinterface

// ==== route_order_fifo.sv ====
`timescale 1ns/1ps

module route_order_fifo #(
    parameter int DEPTH = router_pkg::DEFAULT_ORDER_DEPTH
) (
    input  logic         aclk,
    input  logic         aresetn,
    route_fifo_if.store  fifo
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    router_pkg::route_t tag_mem [DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic             do_push;
    logic             do_pop;

    //////////////////////////////////////////////////
    // Status
    //////////////////////////////////////////////////

    // Occupancy count keeps full and empty apart
    assign fifo.empty    = (fifo.count == '0);
    assign fifo.full     = (fifo.count == CNT_W'(DEPTH));
    assign fifo.head_tag = tag_mem[rd_ptr];

    assign do_push = fifo.push & ~fifo.full;
    assign do_pop  = fifo.pop & ~fifo.empty;

    //////////////////////////////////////////////////
    // Pointers and count
    //////////////////////////////////////////////////

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            wr_ptr <= '0;
        end else if (do_push) begin
            wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
        end
    end

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            rd_ptr <= '0;
        end else if (do_pop) begin
            rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
        end
    end

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            fifo.count <= '0;
        end else begin
            case ({do_push, do_pop})
                2'b10:   fifo.count <= fifo.count + 1'b1;
                2'b01:   fifo.count <= fifo.count - 1'b1;
                default: fifo.count <= fifo.count;
            endcase
        end
    end

    // Tag storage
    always_ff @(posedge aclk) begin
        if (do_push) begin
            tag_mem[wr_ptr] <= fifo.push_tag;
        end
    end

    //////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////

    // Steering must hold off a new request once DEPTH are in flight
    a_no_push_full: assert property (
        @(posedge aclk) disable iff (!aresetn) fifo.full |-> !fifo.push
    ) else $error("route_order_fifo: push while full");

    // A response with no recorded request
    a_no_pop_empty: assert property (
        @(posedge aclk) disable iff (!aresetn) fifo.empty |-> !fifo.pop
    ) else $error("route_order_fifo: pop while empty");

endmodule

// ==== router_cases.txt ====
# channel (0 inst, 1 data)  cached  address (hex)  write  write data (hex)
# first nine inst cached requests fill the order FIFO while responses are held
0 1 9FC00000 0 00000000
0 1 9FC00004 0 00000000
1 1 80001000 0 00000000
0 1 9FC00008 0 00000000
0 1 9FC0000C 0 00000000
1 1 80001004 1 CAFE0001
0 1 9FC00010 0 00000000
0 1 9FC00014 0 00000000
1 0 A0002000 1 12345678
0 1 9FC00018 0 00000000
0 1 9FC0001C 0 00000000
1 0 A0002004 0 00000000
0 1 9FC00020 0 00000000
0 0 BFC00100 0 00000000
1 1 80001008 0 00000000
0 0 BFC00104 0 00000000
1 0 BFD00000 0 00000000
0 1 9FC00200 0 00000000

// ==== router_checker.sv ====
`timescale 1ns/1ps

module router_checker #(
    parameter string       NAME        = "inst",
    parameter string       C_NAME      = "ic",
    parameter string       U_NAME      = "iu",
    parameter int          ORDER_DEPTH = 8,
    parameter logic [31:0] KEY_C       = 32'h0C0C0C0C,
    parameter logic [31:0] KEY_U       = 32'h50505050
) (
    input  logic        aclk,
    input  logic        aresetn,

    // CPU side
    input  logic        req,
    input  logic        cached,
    input  logic        wr,
    input  logic [1:0]  size,
    input  logic [31:0] addr,
    input  logic [31:0] wdata,
    input  logic [3:0]  wstrb,
    input  logic [31:0] rdata,
    input  logic        addr_ok,
    input  logic        data_ok,

    // Paths, write fields as {wr, size, wstrb, wdata}
    input  logic        c_req,
    input  logic [31:0] c_addr,
    input  logic [38:0] c_wfields,
    input  logic        u_req,
    input  logic [31:0] u_addr,
    input  logic [38:0] u_wfields,

    output int          errors,
    output int          max_outstanding
);

    // Entry is {route, wr, expected rdata}
    logic [33:0] exp_q[$];
    logic [33:0] head;
    logic [31:0] exp_data;

    // Top three address bits cleared on the cached path
    function automatic logic [31:0] mmu_map(input logic [31:0] a);
        return {3'b000, a[28:0]};
    endfunction

    task automatic report_mismatch(input string sig, input logic [38:0] exp,
                                   input logic [38:0] act);
        errors++;
        $display("mismatch at %0t: %s expected %h actual %h", $time, sig, exp, act);
    endtask

    task automatic report_failure(input string msg);
        errors++;
        $display("error at %0t: %s channel, %s", $time, NAME, msg);
    endtask

    //////////////////////////////////////////////////
    // Per-cycle checks
    //////////////////////////////////////////////////

    always @(posedge aclk) begin
        if (!aresetn) begin
            exp_q.delete();
            if (c_req || u_req || addr_ok || data_ok)
                report_failure("a strobe is high during reset");
        end else begin
            if (!req && (c_req || u_req))
                report_failure("a path req is high without a CPU req");
            if (c_req && c_addr !== mmu_map(addr))
                report_mismatch({C_NAME, "_addr"}, 39'(mmu_map(addr)), 39'(c_addr));
            if (u_req && u_addr !== addr)
                report_mismatch({U_NAME, "_addr"}, 39'(addr), 39'(u_addr));
            if (c_req && c_wfields !== {wr, size, wstrb, wdata})
                report_mismatch({C_NAME, "_wfields"}, {wr, size, wstrb, wdata}, c_wfields);
            if (u_req && u_wfields !== {wr, size, wstrb, wdata})
                report_mismatch({U_NAME, "_wfields"}, {wr, size, wstrb, wdata}, u_wfields);

            // Oldest entry names the path that owns the channel
            if (exp_q.size() != 0 && (exp_q[0][33] ? u_req : c_req))
                report_failure("other path requested while one has requests outstanding");
            if (exp_q.size() >= ORDER_DEPTH && addr_ok)
                report_failure("addr_ok high with the order depth reached");

            if (data_ok) begin
                if (exp_q.size() == 0) begin
                    report_failure("data_ok with no request outstanding");
                end else begin
                    head = exp_q.pop_front();
                    if (!head[32] && rdata !== head[31:0])
                        report_mismatch({NAME, "_rdata"}, 39'(head[31:0]), 39'(rdata));
                end
            end

            if (req && addr_ok) begin
                exp_data = cached ? (mmu_map(addr) ^ KEY_C) : (addr ^ KEY_U);
                exp_q.push_back({cached, wr, exp_data});
            end
            if (exp_q.size() > ORDER_DEPTH)
                report_failure("more requests outstanding than the order depth");
            if (exp_q.size() > max_outstanding)
                max_outstanding = exp_q.size();
        end
    end

endmodule

// ==== router_pkg.sv ====
package router_pkg;

    //////////////////////////////////////////////////
    // Bus widths
    //////////////////////////////////////////////////

    // Byte address on the CPU side and both paths
    typedef logic [31:0] addr_t;

    typedef logic [31:0] word_t;

    typedef logic [3:0] strb_t;

    // Access size code, passed through untouched
    typedef logic [1:0] size_t;

    // 1 -> cached path, 0 -> uncached path
    typedef logic route_t;

    //////////////////////////////////////////////////
    // Defaults
    //////////////////////////////////////////////////

    // Simple MMU, kseg0/kseg1 fold onto physical space
    localparam int MMU_CLEAR_BITS = 3;

    // Outstanding requests per channel
    localparam int DEFAULT_ORDER_DEPTH = 8;

endpackage

// ==== tb_mem_req_router.sv ====
`timescale 1ns/1ps

module tb_mem_req_router;

    localparam int          ORDER_DEPTH = 8;
    localparam logic [31:0] KEY_C       = 32'h0C0C0C0C;
    localparam logic [31:0] KEY_U       = 32'h50505050;
    localparam logic [31:0] SEED        = 32'h9cc6a4c6;
    localparam int          MAX_CASES   = 64;
    localparam int          HOLD_CYCLES = 80;

    logic        aclk;
    logic        aresetn;
    logic        hold_resp;

    // CPU side
    logic        inst_req, inst_cached, inst_addr_ok, inst_data_ok;
    logic [31:0] inst_addr, inst_rdata;
    logic        data_req, data_cached, data_wr, data_addr_ok, data_data_ok;
    logic [1:0]  data_size;
    logic [3:0]  data_wstrb;
    logic [31:0] data_addr, data_wdata, data_rdata;

    // Downstream paths
    logic        ic_req, ic_addr_ok, ic_data_ok, iu_req, iu_addr_ok, iu_data_ok;
    logic [31:0] ic_addr, ic_rdata, iu_addr, iu_rdata;
    logic        dc_req, dc_wr, dc_addr_ok, dc_data_ok;
    logic        du_req, du_wr, du_addr_ok, du_data_ok;
    logic [1:0]  dc_size, du_size;
    logic [3:0]  dc_wstrb, du_wstrb;
    logic [31:0] dc_addr, dc_wdata, dc_rdata, du_addr, du_wdata, du_rdata;

    int          n_cases;
    logic        case_chan [MAX_CASES];
    logic        case_cached [MAX_CASES];
    logic [31:0] case_addr [MAX_CASES];
    logic        case_wr [MAX_CASES];
    logic [31:0] case_wdata [MAX_CASES];

    int          responses;
    int          cycles;
    int          timeout_limit;
    int          tb_errors;
    int          inst_errors, data_errors, inst_max_out, data_max_out;

    mem_req_router #(.ORDER_DEPTH(ORDER_DEPTH)) uut (.*);

    //////////////////////////////////////////////////
    // Path models and checkers
    //////////////////////////////////////////////////

    path_responder #(.KEY(KEY_C)) u_ic_model (.aclk, .aresetn, .hold(hold_resp),
        .req(ic_req), .addr(ic_addr), .addr_ok(ic_addr_ok), .data_ok(ic_data_ok),
        .rdata(ic_rdata));
    path_responder #(.KEY(KEY_U)) u_iu_model (.aclk, .aresetn, .hold(hold_resp),
        .req(iu_req), .addr(iu_addr), .addr_ok(iu_addr_ok), .data_ok(iu_data_ok),
        .rdata(iu_rdata));
    path_responder #(.KEY(KEY_C)) u_dc_model (.aclk, .aresetn, .hold(hold_resp),
        .req(dc_req), .addr(dc_addr), .addr_ok(dc_addr_ok), .data_ok(dc_data_ok),
        .rdata(dc_rdata));
    path_responder #(.KEY(KEY_U)) u_du_model (.aclk, .aresetn, .hold(hold_resp),
        .req(du_req), .addr(du_addr), .addr_ok(du_addr_ok), .data_ok(du_data_ok),
        .rdata(du_rdata));

    router_checker #(.NAME("inst"), .C_NAME("ic"), .U_NAME("iu"),
        .ORDER_DEPTH(ORDER_DEPTH), .KEY_C(KEY_C), .KEY_U(KEY_U)) u_inst_check (
        .aclk, .aresetn, .req(inst_req), .cached(inst_cached), .wr(1'b0),
        .size(2'b00), .addr(inst_addr), .wdata(32'h0), .wstrb(4'h0),
        .rdata(inst_rdata), .addr_ok(inst_addr_ok), .data_ok(inst_data_ok),
        .c_req(ic_req), .c_addr(ic_addr), .c_wfields(39'h0),
        .u_req(iu_req), .u_addr(iu_addr), .u_wfields(39'h0),
        .errors(inst_errors), .max_outstanding(inst_max_out));

    router_checker #(.NAME("data"), .C_NAME("dc"), .U_NAME("du"),
        .ORDER_DEPTH(ORDER_DEPTH), .KEY_C(KEY_C), .KEY_U(KEY_U)) u_data_check (
        .aclk, .aresetn, .req(data_req), .cached(data_cached), .wr(data_wr),
        .size(data_size), .addr(data_addr), .wdata(data_wdata), .wstrb(data_wstrb),
        .rdata(data_rdata), .addr_ok(data_addr_ok), .data_ok(data_data_ok),
        .c_req(dc_req), .c_addr(dc_addr), .c_wfields({dc_wr, dc_size, dc_wstrb, dc_wdata}),
        .u_req(du_req), .u_addr(du_addr), .u_wfields({du_wr, du_size, du_wstrb, du_wdata}),
        .errors(data_errors), .max_outstanding(data_max_out));

    initial begin
        aclk = 1'b0;
        forever #20 aclk = ~aclk;
    end

    //////////////////////////////////////////////////
    // Cases and stimulus
    //////////////////////////////////////////////////

    task automatic load_cases();
        int          fd;
        int          ch;
        int          cac;
        int          wr;
        logic [31:0] ad;
        logic [31:0] wd;
        string       line;
        n_cases = 0;
        fd = $fopen("router_cases.txt", "r");
        if (fd == 0) begin
            $display("error: cannot open router_cases.txt");
            tb_errors++;
            return;
        end
        while (n_cases < MAX_CASES) begin
            if ($fgets(line, fd) == 0)
                break;
            if (line.len() == 0 || line.getc(0) == "#")
                continue;
            if ($sscanf(line, "%d %d %h %d %h", ch, cac, ad, wr, wd) == 5) begin
                case_chan[n_cases]   = ch[0];
                case_cached[n_cases] = cac[0];
                case_addr[n_cases]   = ad;
                case_wr[n_cases]     = wr[0];
                case_wdata[n_cases]  = wd;
                n_cases++;
            end
        end
        $fclose(fd);
        if (n_cases == 0) begin
            $display("error: no cases found in router_cases.txt");
            tb_errors++;
        end
    endtask

    task automatic drive_req(input int ch, input int i, input logic on);
        if (ch == 0) begin
            inst_req    = on;
            inst_cached = case_cached[i];
            inst_addr   = case_addr[i];
        end else begin
            data_req    = on;
            data_cached = case_cached[i];
            data_addr   = case_addr[i];
            data_wr     = case_wr[i];
            data_wdata  = case_wdata[i];
            data_size   = 2'd2;
            data_wstrb  = 4'hF;
        end
    endtask

    function automatic logic accepted(input int ch);
        if (ch == 0)
            return inst_req & inst_addr_ok;
        return data_req & data_addr_ok;
    endfunction

    // Leading same-path requests of a channel pile up while responses are held
    function automatic int leading_run(input int ch);
        int   run;
        logic path;
        run  = 0;
        path = 1'b0;
        for (int i = 0; i < n_cases; i++) begin
            if (case_chan[i] == ch[0]) begin
                if (run == 0)
                    path = case_cached[i];
                else if (case_cached[i] != path)
                    break;
                run++;
            end
        end
        return (run > ORDER_DEPTH) ? ORDER_DEPTH : run;
    endfunction

    task automatic check_peak(input string name, input int peak, input int ch);
        int expected;
        expected = leading_run(ch);
        if (peak < expected) begin
            $display("error: %s channel peaked at %0d outstanding requests, expected %0d",
                     name, peak, expected);
            tb_errors++;
        end
    endtask

    // Holds each request until the DUT takes it
    task automatic run_channel(input int ch);
        for (int i = 0; i < n_cases; i++) begin
            if (case_chan[i] == ch[0]) begin
                drive_req(ch, i, 1'b1);
                @(posedge aclk);
                while (!accepted(ch))
                    @(posedge aclk);
                #1;
            end
        end
        drive_req(ch, 0, 1'b0);
    endtask

    task automatic print_counts();
        $display("errors: inst checker %0d, data checker %0d, testbench %0d",
                 inst_errors, data_errors, tb_errors);
    endtask

    initial begin
        void'($urandom(SEED));
        timeout_limit = 1000;
        aresetn       = 1'b0;
        hold_resp     = 1'b1;
        inst_req      = 1'b0;
        inst_cached   = 1'b0;
        inst_addr     = '0;
        data_req      = 1'b0;
        data_cached   = 1'b0;
        data_wr       = 1'b0;
        data_size     = '0;
        data_addr     = '0;
        data_wdata    = '0;
        data_wstrb    = '0;
        load_cases();
        timeout_limit = n_cases * 64 + 200;
        repeat (8) @(posedge aclk);
        #1;
        aresetn = 1'b1;
        fork
            run_channel(0);
            run_channel(1);
            begin
                // No responses at first, so the order FIFO fills up
                repeat (HOLD_CYCLES) @(posedge aclk);
                #1;
                hold_resp = 1'b0;
            end
        join
        while (responses < n_cases)
            @(posedge aclk);
        repeat (4) @(posedge aclk);
        check_peak("instruction", inst_max_out, 0);
        check_peak("data", data_max_out, 1);
        print_counts();
        if (tb_errors + inst_errors + data_errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    always @(posedge aclk) begin
        cycles = cycles + 1;
        if (aresetn)
            responses = responses + int'(inst_data_ok) + int'(data_data_ok);
        if (cycles > timeout_limit) begin
            $display("timeout: run did not finish within %0d cycles", timeout_limit);
            print_counts();
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

endmodule

// One downstream path, answers in order after 1 to 6 cycles
module path_responder #(
    parameter logic [31:0] KEY = 32'h0
) (
    input  logic        aclk,
    input  logic        aresetn,
    input  logic        hold,
    input  logic        req,
    input  logic [31:0] addr,
    output logic        addr_ok,
    output logic        data_ok,
    output logic [31:0] rdata
);

    logic [31:0] pending[$];
    int          wait_cnt;
    logic        held;

    initial begin
        addr_ok = 1'b0;
        data_ok = 1'b0;
        rdata   = '0;
    end

    always @(posedge aclk) begin
        if (!aresetn) begin
            pending.delete();
            wait_cnt = 0;
            #1;
            addr_ok = 1'b0;
            data_ok = 1'b0;
        end else begin
            // Retire last cycle's answer before taking a new request
            if (data_ok)
                void'(pending.pop_front());
            if (req && addr_ok)
                pending.push_back(addr);
            held = hold;
            #1;
            addr_ok = ($urandom % 4) != 0;
            data_ok = 1'b0;
            if (pending.size() != 0 && !held) begin
                if (wait_cnt == 0)
                    wait_cnt = 1 + int'($urandom % 6);
                wait_cnt = wait_cnt - 1;
                if (wait_cnt == 0) begin
                    data_ok = 1'b1;
                    rdata   = pending[0] ^ KEY;
                end
            end
        end
    end

endmodule

// ==== vlog.f ====
router_pkg.sv
route_fifo_if.sv
route_order_fifo.sv
req_route_channel.sv
mem_req_router.sv
router_checker.sv
tb_mem_req_router.sv
